// ==== verilog/gm_pkg.sv ====
package gm_pkg;

	// ------------------------------
	// DTL bus widths
	// ------------------------------

	localparam int dtl_data_width = 32;
	localparam int dtl_addr_width = 32;
	localparam int dtl_num_enables = dtl_data_width / 8;

	// low address bits that pick a byte inside a word
	localparam int dtl_byte_offset = 2;

	// ------------------------------
	// opcodes and states
	// ------------------------------

	// read is 1, as on the DTL read/write line
	typedef enum logic
	{
		dtl_write = 1'b0,
		dtl_read = 1'b1
	} dtl_op_e;

	typedef enum logic [1:0]
	{
		ctrl_idle = 2'd0,
		ctrl_read = 2'd1,
		ctrl_respond = 2'd2
	} ctrl_state_e;

	// ------------------------------
	// channel payloads
	// ------------------------------

	// single beat command, write data rides along
	typedef struct packed
	{
		dtl_op_e op;
		logic [dtl_addr_width-1:0] addr;
		logic [dtl_data_width-1:0] wr_data;
		logic [dtl_num_enables-1:0] wr_mask;
	} dtl_req_t;

	typedef struct packed
	{
		logic [dtl_data_width-1:0] rd_data;
	} dtl_rsp_t;

endpackage

// ==== verilog/gm_ram.sv ====
`timescale 1ns/100ps

module gm_ram
#(
	parameter int unsigned mem_addr_width = 8
)
(
	input  logic clk,
	input  logic [gm_pkg::dtl_num_enables-1:0] we,
	input  logic [mem_addr_width-1:0] addr,
	input  logic [gm_pkg::dtl_data_width-1:0] wr_data,
	output logic [gm_pkg::dtl_data_width-1:0] rd_data
);

	localparam int byte_width = gm_pkg::dtl_data_width / gm_pkg::dtl_num_enables;

	logic [gm_pkg::dtl_data_width-1:0] mem [2**mem_addr_width];

	// per byte write
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < gm_pkg::dtl_num_enables; i++)
		begin
			if (we[i])
				mem[addr][i*byte_width +: byte_width] <= wr_data[i*byte_width +: byte_width];
		end
	end

	// registered read, one cycle latency
	always_ff @(posedge clk)
	begin
		rd_data <= mem[addr];
	end

endmodule

// ==== verilog/dtl_sram_controller.sv ====
`timescale 1ns/100ps

module dtl_sram_controller
#(
	parameter int unsigned mem_addr_width = 8
)
(
	input  logic clk,
	input  logic rst_n,

	// slave side from the isolator
	input  gm_pkg::dtl_req_t in_req,
	input  logic in_cmd_valid,
	output logic in_cmd_accept,
	output gm_pkg::dtl_rsp_t in_rsp,
	output logic in_rd_valid,
	input  logic in_rd_accept,

	// RAM side
	output logic [gm_pkg::dtl_num_enables-1:0] ram_we,
	output logic [mem_addr_width-1:0] ram_addr,
	output logic [gm_pkg::dtl_data_width-1:0] ram_wr_data,
	input  logic [gm_pkg::dtl_data_width-1:0] ram_rd_data
);

	gm_pkg::ctrl_state_e state;
	gm_pkg::ctrl_state_e state_next;
	gm_pkg::dtl_rsp_t rsp_q;
	logic cmd_fire;

	assign in_cmd_accept = (state == gm_pkg::ctrl_idle);
	assign cmd_fire = in_cmd_valid && in_cmd_accept;

	// ------------------------------
	// RAM access
	// ------------------------------

	// word index, byte offset dropped
	assign ram_addr = in_req.addr[gm_pkg::dtl_byte_offset +: mem_addr_width];
	assign ram_wr_data = in_req.wr_data;
	assign ram_we = (cmd_fire && in_req.op == gm_pkg::dtl_write) ? in_req.wr_mask : '0;

	// ------------------------------
	// FSM
	// ------------------------------

	always_comb
	begin
		state_next = state;
		case (state)
			gm_pkg::ctrl_idle:
				if (cmd_fire && in_req.op == gm_pkg::dtl_read)
					state_next = gm_pkg::ctrl_read;
			gm_pkg::ctrl_read:
				state_next = gm_pkg::ctrl_respond;
			gm_pkg::ctrl_respond:
				if (in_rd_accept)
					state_next = gm_pkg::ctrl_idle;
			default:
				state_next = gm_pkg::ctrl_idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= gm_pkg::ctrl_idle;
		else
			state <= state_next;
	end

	// RAM output is valid one cycle after the accept
	always_ff @(posedge clk)
	begin
		if (state == gm_pkg::ctrl_read)
			rsp_q.rd_data <= ram_rd_data;
	end

	assign in_rsp = rsp_q;
	assign in_rd_valid = (state == gm_pkg::ctrl_respond);

endmodule

// ==== verilog/dtl_address_isolator.sv ====
`timescale 1ns/100ps

module dtl_address_isolator
#(
	parameter logic [gm_pkg::dtl_addr_width-1:0] range_low = '0,
	parameter logic [gm_pkg::dtl_addr_width-1:0] range_high = 32'd1023
)
(
	input  logic clk,
	input  logic rst_n,

	// slave side from the arbiter
	input  gm_pkg::dtl_req_t in_req,
	input  logic in_cmd_valid,
	output logic in_cmd_accept,
	output gm_pkg::dtl_rsp_t in_rsp,
	output logic in_rd_valid,
	input  logic in_rd_accept,

	// master side towards the memory controller
	output gm_pkg::dtl_req_t out_req,
	output logic out_cmd_valid,
	input  logic out_cmd_accept,
	input  gm_pkg::dtl_rsp_t out_rsp,
	input  logic out_rd_valid,
	output logic out_rd_accept
);

	logic in_range;
	// local zero response for an out-of-range read
	logic pending;
	logic local_read;

	// ------------------------------
	// address window
	// ------------------------------

	assign in_range = (in_req.addr >= range_low) && (in_req.addr <= range_high);

	assign out_req = in_req;
	assign out_cmd_valid = in_cmd_valid && in_range && !pending;

	// out-of-range commands are swallowed right away
	always_comb
	begin
		if (pending)
			in_cmd_accept = 1'b0;
		else if (in_range)
			in_cmd_accept = out_cmd_accept;
		else
			in_cmd_accept = 1'b1;
	end

	assign local_read = in_cmd_valid && in_cmd_accept && !in_range
		&& in_req.op == gm_pkg::dtl_read;

	// ------------------------------
	// response side
	// ------------------------------

	assign in_rd_valid = pending || out_rd_valid;
	assign in_rsp = pending ? '0 : out_rsp;
	assign out_rd_accept = in_rd_accept && !pending;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pending <= 1'b0;
		else if (local_read)
			pending <= 1'b1;
		else if (pending && in_rd_accept)
			pending <= 1'b0;
	end

endmodule

// ==== verilog/dtl_arbiter.sv ====
`timescale 1ns/100ps

module dtl_arbiter
(
	input  logic clk,
	input  logic rst_n,

	// slave side, index 0 is the host port and index 1 the accelerator
	input  gm_pkg::dtl_req_t [1:0] in_req,
	input  logic [1:0] in_cmd_valid,
	output logic [1:0] in_cmd_accept,
	output gm_pkg::dtl_rsp_t [1:0] in_rsp,
	output logic [1:0] in_rd_valid,
	input  logic [1:0] in_rd_accept,

	// master side towards the memory
	output gm_pkg::dtl_req_t out_req,
	output logic out_cmd_valid,
	input  logic out_cmd_accept,
	input  gm_pkg::dtl_rsp_t out_rsp,
	input  logic out_rd_valid,
	output logic out_rd_accept
);

	// read outstanding, held until its response transfers
	logic lock;
	// port that owns the outstanding read
	logic owner;
	// winner of the last contended grant
	logic last_port;
	logic sel;
	logic contended;
	logic cmd_fire;
	logic rsp_fire;

	// ------------------------------
	// grant
	// ------------------------------

	assign contended = in_cmd_valid[0] && in_cmd_valid[1];

	always_comb
	begin
		if (contended)
			sel = ~last_port;
		else
			sel = in_cmd_valid[1];
	end

	assign out_req = in_req[sel];
	assign out_cmd_valid = !lock && in_cmd_valid[sel];

	assign cmd_fire = out_cmd_valid && out_cmd_accept;
	assign rsp_fire = out_rd_valid && out_rd_accept;

	// accept stays up on an idle port unless the other one holds the grant
	always_comb
	begin
		for (int i = 0; i < 2; i++)
		begin
			in_cmd_accept[i] = !lock && out_cmd_accept
				&& (sel == 1'(i) || !in_cmd_valid[sel]);
		end
	end

	// ------------------------------
	// response routing
	// ------------------------------

	always_comb
	begin
		for (int i = 0; i < 2; i++)
		begin
			in_rd_valid[i] = lock && out_rd_valid && (owner == 1'(i));
			in_rsp[i] = (owner == 1'(i)) ? out_rsp : '0;
		end
	end

	assign out_rd_accept = lock && in_rd_accept[owner];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			lock <= 1'b0;
			owner <= 1'b0;
			// host wins the first contended grant
			last_port <= 1'b1;
		end
		else
		begin
			if (cmd_fire && out_req.op == gm_pkg::dtl_read)
			begin
				lock <= 1'b1;
				owner <= sel;
			end
			else if (rsp_fire)
				lock <= 1'b0;

			if (cmd_fire && contended)
				last_port <= sel;
		end
	end

endmodule

// ==== verilog/gm_subsystem.sv ====
`timescale 1ns/100ps

module gm_subsystem
#(
	parameter int unsigned mem_addr_width = 8,
	parameter logic [gm_pkg::dtl_addr_width-1:0] range_low = '0,
	parameter logic [gm_pkg::dtl_addr_width-1:0] range_high = 32'd1023
)
(
	input  logic clk,
	input  logic rst_n,

	// host master
	input  gm_pkg::dtl_req_t h_req,
	input  logic h_cmd_valid,
	output logic h_cmd_accept,
	output gm_pkg::dtl_rsp_t h_rsp,
	output logic h_rd_valid,
	input  logic h_rd_accept,

	// accelerator master
	input  gm_pkg::dtl_req_t a_req,
	input  logic a_cmd_valid,
	output logic a_cmd_accept,
	output gm_pkg::dtl_rsp_t a_rsp,
	output logic a_rd_valid,
	input  logic a_rd_accept
);

	// arbiter to isolator
	gm_pkg::dtl_req_t arb_req;
	logic arb_cmd_valid;
	logic arb_cmd_accept;
	gm_pkg::dtl_rsp_t arb_rsp;
	logic arb_rd_valid;
	logic arb_rd_accept;

	// isolator to controller
	gm_pkg::dtl_req_t iso_req;
	logic iso_cmd_valid;
	logic iso_cmd_accept;
	gm_pkg::dtl_rsp_t iso_rsp;
	logic iso_rd_valid;
	logic iso_rd_accept;

	// controller to RAM
	logic [gm_pkg::dtl_num_enables-1:0] ram_we;
	logic [mem_addr_width-1:0] ram_addr;
	logic [gm_pkg::dtl_data_width-1:0] ram_wr_data;
	logic [gm_pkg::dtl_data_width-1:0] ram_rd_data;

	dtl_arbiter arbiter_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.in_req({a_req, h_req}),
		.in_cmd_valid({a_cmd_valid, h_cmd_valid}),
		.in_cmd_accept({a_cmd_accept, h_cmd_accept}),
		.in_rsp({a_rsp, h_rsp}),
		.in_rd_valid({a_rd_valid, h_rd_valid}),
		.in_rd_accept({a_rd_accept, h_rd_accept}),
		.out_req(arb_req),
		.out_cmd_valid(arb_cmd_valid),
		.out_cmd_accept(arb_cmd_accept),
		.out_rsp(arb_rsp),
		.out_rd_valid(arb_rd_valid),
		.out_rd_accept(arb_rd_accept)
	);

	dtl_address_isolator
	#(
		.range_low(range_low),
		.range_high(range_high)
	)
	isolator_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.in_req(arb_req),
		.in_cmd_valid(arb_cmd_valid),
		.in_cmd_accept(arb_cmd_accept),
		.in_rsp(arb_rsp),
		.in_rd_valid(arb_rd_valid),
		.in_rd_accept(arb_rd_accept),
		.out_req(iso_req),
		.out_cmd_valid(iso_cmd_valid),
		.out_cmd_accept(iso_cmd_accept),
		.out_rsp(iso_rsp),
		.out_rd_valid(iso_rd_valid),
		.out_rd_accept(iso_rd_accept)
	);

	dtl_sram_controller
	#(
		.mem_addr_width(mem_addr_width)
	)
	controller_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.in_req(iso_req),
		.in_cmd_valid(iso_cmd_valid),
		.in_cmd_accept(iso_cmd_accept),
		.in_rsp(iso_rsp),
		.in_rd_valid(iso_rd_valid),
		.in_rd_accept(iso_rd_accept),
		.ram_we(ram_we),
		.ram_addr(ram_addr),
		.ram_wr_data(ram_wr_data),
		.ram_rd_data(ram_rd_data)
	);

	// global data memory
	gm_ram
	#(
		.mem_addr_width(mem_addr_width)
	)
	ram_inst
	(
		.clk(clk),
		.we(ram_we),
		.addr(ram_addr),
		.wr_data(ram_wr_data),
		.rd_data(ram_rd_data)
	);

endmodule

// ==== verification/gm_subsystem_checker.sv ====
`timescale 1ns/100ps

module gm_subsystem_checker
(
	input  logic clk,
	input  logic rst_n,
	input  logic h_cmd_accept,
	input  gm_pkg::dtl_rsp_t h_rsp,
	input  logic h_rd_valid,
	input  logic h_rd_accept,
	input  logic a_cmd_accept,
	input  gm_pkg::dtl_rsp_t a_rsp,
	input  logic a_rd_valid,
	input  logic a_rd_accept
);

	// count of failed assertions
	int unsigned failures = 0;

	// response held under back-pressure
	h_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
		h_rd_valid && !h_rd_accept |=> h_rd_valid && $stable(h_rsp))
		else
		begin
			failures++;
			$error("h response changed while rd_accept was low");
		end

	a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
		a_rd_valid && !a_rd_accept |=> a_rd_valid && $stable(a_rsp))
		else
		begin
			failures++;
			$error("a response changed while rd_accept was low");
		end

	// only the owner of the outstanding read sees it
	one_rd_valid: assert property (@(posedge clk) disable iff (!rst_n)
		!(h_rd_valid && a_rd_valid))
		else
		begin
			failures++;
			$error("rd_valid high on both ports");
		end

	// first cycle out of reset
	reset_state: assert property (@(posedge clk)
		$rose(rst_n) |-> h_cmd_accept && a_cmd_accept && !h_rd_valid && !a_rd_valid)
		else
		begin
			failures++;
			$error("handshake outputs wrong after reset");
		end

endmodule

bind gm_subsystem gm_subsystem_checker checker_inst
(
	.clk(clk),
	.rst_n(rst_n),
	.h_cmd_accept(h_cmd_accept),
	.h_rsp(h_rsp),
	.h_rd_valid(h_rd_valid),
	.h_rd_accept(h_rd_accept),
	.a_cmd_accept(a_cmd_accept),
	.a_rsp(a_rsp),
	.a_rd_valid(a_rd_valid),
	.a_rd_accept(a_rd_accept)
);

// ==== verification/gm_subsystem_tb.sv ====
`timescale 1ns/100ps

module gm_subsystem_tb;

	localparam int unsigned mem_addr_width = 8;
	localparam logic [31:0] range_low = 32'd0;
	localparam logic [31:0] range_high = 32'd1023;
	localparam int num_rows = 15;
	localparam int timeout_cycles = num_rows * 20 + 16;
	localparam int wait_limit = 20;
	localparam gm_pkg::dtl_op_e wr = gm_pkg::dtl_write;
	localparam gm_pkg::dtl_op_e rd = gm_pkg::dtl_read;

	// simul starts the row together with the next one, stall holds rd_accept low
	typedef struct
	{
		string name;
		bit port;
		gm_pkg::dtl_op_e op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0] mask;
		bit simul;
		bit stall;
	} row_t;

	logic clk;
	logic rst_n;
	gm_pkg::dtl_req_t [1:0] req;
	logic [1:0] cmd_valid;
	logic [1:0] cmd_accept;
	gm_pkg::dtl_rsp_t [1:0] rsp;
	logic [1:0] rd_valid;
	logic [1:0] rd_accept;

	row_t rows [num_rows];
	logic [31:0] ref_mem [2**mem_addr_width];
	int accept_order [2];
	int accept_seq;
	int value_errors;
	int handshake_errors;
	int assertion_errors;
	int cycles;
	bit last_winner;

	gm_subsystem
	#(
		.mem_addr_width(mem_addr_width),
		.range_low(range_low),
		.range_high(range_high)
	)
	dut
	(
		.clk(clk),
		.rst_n(rst_n),
		.h_req(req[0]),
		.h_cmd_valid(cmd_valid[0]),
		.h_cmd_accept(cmd_accept[0]),
		.h_rsp(rsp[0]),
		.h_rd_valid(rd_valid[0]),
		.h_rd_accept(rd_accept[0]),
		.a_req(req[1]),
		.a_cmd_valid(cmd_valid[1]),
		.a_cmd_accept(cmd_accept[1]),
		.a_rsp(rsp[1]),
		.a_rd_valid(rd_valid[1]),
		.a_rd_accept(rd_accept[1])
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------
	// reference model and checks
	// ------------------------------

	function automatic string port_name(input int p);
		return (p == 0) ? "h" : "a";
	endfunction

	// updates the reference memory, returns the expected read data
	function automatic gm_pkg::dtl_rsp_t model_access(input gm_pkg::dtl_req_t cmd);
		gm_pkg::dtl_rsp_t rsp_exp;
		int unsigned word;

		rsp_exp.rd_data = '0;
		word = cmd.addr[gm_pkg::dtl_byte_offset +: mem_addr_width];
		if (cmd.addr >= range_low && cmd.addr <= range_high)
		begin
			if (cmd.op == wr)
			begin
				for (int b = 0; b < 4; b++)
				begin
					if (cmd.wr_mask[b])
						ref_mem[word][b*8 +: 8] = cmd.wr_data[b*8 +: 8];
				end
			end
			else
				rsp_exp.rd_data = ref_mem[word];
		end
		return rsp_exp;
	endfunction

	task automatic check_rsp(input string name, input gm_pkg::dtl_rsp_t expected,
		input gm_pkg::dtl_rsp_t actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: expected rd_data %h, actual %h", name,
				expected.rd_data, actual.rd_data);
			value_errors++;
		end
	endtask

	task automatic check_port(input string name, input bit expected, input bit actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: expected first port %s, actual %s", name,
				port_name(expected), port_name(actual));
			value_errors++;
		end
	endtask

	// ------------------------------
	// one row on one port
	// ------------------------------

	task automatic drive_row(input int idx);
		row_t r;
		int p;
		int waited;
		gm_pkg::dtl_req_t cmd;
		gm_pkg::dtl_rsp_t expected;
		gm_pkg::dtl_rsp_t held;

		r = rows[idx];
		p = int'(r.port);
		cmd.op = r.op;
		cmd.addr = r.addr;
		cmd.wr_data = r.data;
		cmd.wr_mask = r.mask;
		@(posedge clk);
		req[p] <= cmd;
		cmd_valid[p] <= 1'b1;
		rd_accept[p] <= !r.stall;
		waited = 0;
		@(negedge clk);
		while (!cmd_accept[p] && waited < wait_limit)
		begin
			waited++;
			@(negedge clk);
		end
		if (!cmd_accept[p])
		begin
			$display("port %s: command of %s was never accepted", port_name(p), r.name);
			handshake_errors++;
			@(posedge clk);
			cmd_valid[p] <= 1'b0;
			rd_accept[p] <= 1'b1;
			return;
		end
		// command transfers at the coming edge
		accept_order[p] = accept_seq;
		accept_seq++;
		expected = model_access(cmd);
		@(posedge clk);
		cmd_valid[p] <= 1'b0;
		if (r.op == wr)
			return;
		waited = 0;
		@(negedge clk);
		while (!rd_valid[p] && waited < wait_limit)
		begin
			waited++;
			@(negedge clk);
		end
		if (!rd_valid[p])
		begin
			$display("port %s: no read response for %s", port_name(p), r.name);
			handshake_errors++;
			@(posedge clk);
			rd_accept[p] <= 1'b1;
			return;
		end
		if (r.stall)
		begin
			held = rsp[p];
			repeat ($urandom_range(2, 6))
			begin
				@(negedge clk);
				if (!rd_valid[p] || rsp[p] !== held)
				begin
					$display("port %s: response of %s did not hold while stalled",
						port_name(p), r.name);
					handshake_errors++;
				end
				if (|(cmd_valid & cmd_accept))
				begin
					$display("a command was accepted while the read of %s was pending", r.name);
					handshake_errors++;
				end
			end
			@(posedge clk);
			rd_accept[p] <= 1'b1;
			@(negedge clk);
		end
		check_rsp(r.name, expected, rsp[p]);
		@(posedge clk);
	endtask

	// ------------------------------
	// stimulus
	// ------------------------------

	initial
	begin
		int i;
		bit first;

		void'($urandom(32'h899d_847e));
		rst_n = 1'b0;
		req = '0;
		cmd_valid = '0;
		rd_accept = '1;
		accept_seq = 0;
		value_errors = 0;
		handshake_errors = 0;
		assertion_errors = 0;
		// h wins the first contended grant
		last_winner = 1'b1;

		rows[0] = '{"contend_wr_h", 0, wr, 32'h010, 32'h1111_1111, 4'hf, 1, 0};
		rows[1] = '{"contend_wr_a", 1, wr, 32'h020, 32'h2222_2222, 4'hf, 0, 0};
		rows[2] = '{"contend_rd_h", 0, rd, 32'h020, 32'h0, 4'h0, 1, 0};
		rows[3] = '{"contend_rd_a", 1, rd, 32'h010, 32'h0, 4'h0, 0, 0};
		rows[4] = '{"full_wr_h", 0, wr, 32'h040, 32'hdead_beef, 4'hf, 0, 0};
		rows[5] = '{"full_rd_a", 1, rd, 32'h040, 32'h0, 4'h0, 0, 0};
		rows[6] = '{"mask_wr_a", 1, wr, 32'h040, 32'h1234_5678, 4'b0101, 0, 0};
		rows[7] = '{"mask_rd_h", 0, rd, 32'h040, 32'h0, 4'h0, 0, 0};
		rows[8] = '{"base_wr_a", 1, wr, 32'h000, 32'h0bad_f00d, 4'hf, 0, 0};
		// 0x400 aliases word 0 if it got through
		rows[9] = '{"oor_wr_h", 0, wr, 32'h400, 32'hffff_ffff, 4'hf, 0, 0};
		rows[10] = '{"base_rd_a", 1, rd, 32'h000, 32'h0, 4'h0, 0, 0};
		rows[11] = '{"oor_rd_h", 0, rd, 32'h404, 32'h0, 4'h0, 0, 0};
		rows[12] = '{"stall_rd_h", 0, rd, 32'h010, 32'h0, 4'h0, 1, 1};
		rows[13] = '{"stall_wr_a", 1, wr, 32'h044, 32'h5555_aaaa, 4'hf, 0, 0};
		rows[14] = '{"stall_rd_a", 1, rd, 32'h044, 32'h0, 4'h0, 0, 1};

		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		i = 0;
		while (i < num_rows)
		begin
			if (i > 0)
				repeat ($urandom_range(0, 3)) @(posedge clk);
			if (rows[i].simul)
			begin
				fork
					drive_row(i);
					drive_row(i + 1);
				join
				first = (accept_order[1] < accept_order[0]);
				check_port(rows[i].name, ~last_winner, first);
				last_winner = ~last_winner;
				i += 2;
			end
			else
			begin
				drive_row(i);
				i++;
			end
		end

		repeat (2) @(posedge clk);
		assertion_errors = dut.checker_inst.failures;
		$display("errors: %0d value, %0d handshake, %0d assertion", value_errors,
			handshake_errors, assertion_errors);
		if (value_errors == 0 && handshake_errors == 0 && assertion_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial
	begin
		cycles = 0;
		while (cycles < timeout_cycles)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", timeout_cycles);
		$display("Test failed");
		$finish;
	end

endmodule

// ==== project.f ====
verilog/gm_pkg.sv
verilog/gm_ram.sv
verilog/dtl_sram_controller.sv
verilog/dtl_address_isolator.sv
verilog/dtl_arbiter.sv
verilog/gm_subsystem.sv
verification/gm_subsystem_checker.sv
verification/gm_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: gm_subsystem

sources:
  - verilog/gm_pkg.sv
  - verilog/gm_ram.sv
  - verilog/dtl_sram_controller.sv
  - verilog/dtl_address_isolator.sv
  - verilog/dtl_arbiter.sv
  - verilog/gm_subsystem.sv
  - target: test
    files:
      - verification/gm_subsystem_checker.sv
      - verification/gm_subsystem_tb.sv
